// ==== rtl/spike_gen_pkg.sv ====
package spike_gen_pkg;

  // number of generators in the array
  localparam int n_gens = 8;

  // generator index width to address n_gens entries
  localparam int n_gen_idx = 3;

  // period and countdown width in time units
  localparam int n_period = 16;

  // destination tag width
  localparam int n_tag = 11;

  // per-generator spike count that wraps at the top
  localparam int n_ct = 10;

  // sweep controller states
  //   idle        waiting for a unit pulse or a programming request
  //   prog_write  writing a programmed entry, prog_a follows
  //   read        entry at the sweep index is being captured
  //   update      next countdown and count are written back
  //   emit_wait   spike ready but the output register is still full
  //   next        advance the index or close the sweep
  typedef enum logic [2:0] {
    idle       = 3'd0,
    prog_write = 3'd1,
    read       = 3'd2,
    update     = 3'd3,
    emit_wait  = 3'd4,
    next       = 3'd5
  } sweep_state_e;

endpackage

// ==== rtl/gen_state_mem.sv ====
`timescale 1ns/1ns

module gen_state_mem (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [spike_gen_pkg::n_gen_idx-1:0] rd_idx,
  input  logic                                we,
  input  logic [spike_gen_pkg::n_gen_idx-1:0] wr_idx,
  input  logic                                wr_from_prog,
  input  logic [spike_gen_pkg::n_period-1:0]  prog_period,
  input  logic [spike_gen_pkg::n_period-1:0]  prog_ticks,
  input  logic [spike_gen_pkg::n_tag-1:0]     prog_tag,
  input  logic [spike_gen_pkg::n_period-1:0]  next_ticks,
  input  logic [spike_gen_pkg::n_ct-1:0]      next_ct,
  output logic [spike_gen_pkg::n_period-1:0]  rd_period,
  output logic [spike_gen_pkg::n_period-1:0]  rd_ticks,
  output logic [spike_gen_pkg::n_tag-1:0]     rd_tag,
  output logic [spike_gen_pkg::n_ct-1:0]      rd_ct,
  output logic                                rd_valid
);

  logic [spike_gen_pkg::n_period-1:0] period_r [spike_gen_pkg::n_gens];
  logic [spike_gen_pkg::n_period-1:0] ticks_r  [spike_gen_pkg::n_gens];
  logic [spike_gen_pkg::n_tag-1:0]    tag_r    [spike_gen_pkg::n_gens];
  logic [spike_gen_pkg::n_ct-1:0]     ct_r     [spike_gen_pkg::n_gens];
  logic [spike_gen_pkg::n_gens-1:0]   valid_r;

  // programmed flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_r <= '0;
    end else if (we && wr_from_prog) begin
      valid_r[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      if (wr_from_prog) begin
        period_r[wr_idx] <= prog_period;
        ticks_r[wr_idx]  <= prog_ticks;
        tag_r[wr_idx]    <= prog_tag;
        ct_r[wr_idx]     <= '0;
      end else begin
        // sweep write-back leaves period and tag alone
        ticks_r[wr_idx] <= next_ticks;
        ct_r[wr_idx]    <= next_ct;
      end
    end
  end

  assign rd_period = period_r[rd_idx];
  assign rd_ticks  = ticks_r[rd_idx];
  assign rd_tag    = tag_r[rd_idx];
  assign rd_ct     = ct_r[rd_idx];
  assign rd_valid  = valid_r[rd_idx];

endmodule

// ==== rtl/gen_tick_update.sv ====
`timescale 1ns/1ns

module gen_tick_update (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [spike_gen_pkg::n_period-1:0] period,
  input  logic [spike_gen_pkg::n_period-1:0] ticks,
  input  logic [spike_gen_pkg::n_ct-1:0]     ct,
  input  logic                               en,
  output logic                               fire,
  output logic [spike_gen_pkg::n_period-1:0] next_ticks,
  output logic [spike_gen_pkg::n_ct-1:0]     next_ct
);

  logic [spike_gen_pkg::n_period-1:0] period_q;
  logic [spike_gen_pkg::n_period-1:0] ticks_q;
  logic [spike_gen_pkg::n_ct-1:0]     ct_q;
  logic [spike_gen_pkg::n_period-1:0] period_eff;

  // entry captured during read for the update step
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      period_q <= '0;
      ticks_q  <= '0;
      ct_q     <= '0;
    end else begin
      period_q <= period;
      ticks_q  <= ticks;
      ct_q     <= ct;
    end
  end

  // a period of 0 runs as a period of 1
  assign period_eff = (period_q == '0) ? spike_gen_pkg::n_period'(1) : period_q;

  assign fire = (ticks_q == '0);

  assign next_ticks = fire ? period_eff - 1'b1 : ticks_q - 1'b1;

  // count wraps naturally at n_ct bits
  assign next_ct = (fire && en) ? ct_q + 1'b1 : ct_q;

endmodule

// ==== rtl/spike_out_reg.sv ====
`timescale 1ns/1ns

module spike_out_reg (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           load,
  input  logic [spike_gen_pkg::n_tag-1:0] tag,
  input  logic [spike_gen_pkg::n_ct-1:0]  ct,
  input  logic                           out_a,
  output logic                           out_v,
  output logic [spike_gen_pkg::n_tag-1:0] out_tag,
  output logic [spike_gen_pkg::n_ct-1:0]  out_ct,
  output logic                           busy
);

  // load wins over a transfer in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_v <= 1'b0;
    end else if (load) begin
      out_v <= 1'b1;
    end else if (out_a) begin
      out_v <= 1'b0;
    end
  end

  // spike word stays put while out_v is high
  always_ff @(posedge clk) begin
    if (load) begin
      out_tag <= tag;
      out_ct  <= ct;
    end
  end

  // controller only loads into an empty register
  assign busy = out_v;

endmodule

// ==== rtl/spike_sweep_ctrl.sv ====
`timescale 1ns/1ns

module spike_sweep_ctrl (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                unit_pulse,
  input  logic [spike_gen_pkg::n_gen_idx:0]   gens_used,
  input  logic [spike_gen_pkg::n_gens-1:0]    gens_en,
  input  logic                                prog_v,
  input  logic [spike_gen_pkg::n_gen_idx-1:0] prog_gen_idx,
  input  logic                                fire,
  input  logic                                out_busy,
  input  logic                                entry_valid,
  output logic                                prog_a,
  output logic [spike_gen_pkg::n_gen_idx-1:0] mem_rd_idx,
  output logic                                mem_we,
  output logic [spike_gen_pkg::n_gen_idx-1:0] mem_wr_idx,
  output logic                                wr_from_prog,
  output logic                                out_load
);

  spike_gen_pkg::sweep_state_e state;

  logic [spike_gen_pkg::n_gen_idx-1:0] idx;
  logic [spike_gen_pkg::n_gen_idx:0]   used_q;
  logic [spike_gen_pkg::n_gen_idx:0]   used_clamped;
  logic [spike_gen_pkg::n_gens-1:0]    en_q;
  logic                                pending;
  logic                                prog_armed;
  logic                                start;
  logic                                emit;
  logic                                last_gen;

  // gens_used is 4 bits wide but only n_gens entries exist
  assign used_clamped = (gens_used > spike_gen_pkg::n_gens) ?
                        (spike_gen_pkg::n_gen_idx + 1)'(spike_gen_pkg::n_gens) :
                        gens_used;

  assign start    = unit_pulse || pending;
  assign emit     = fire && en_q[idx];
  assign last_gen = ({1'b0, idx} + 1'b1) >= used_q;

  assign mem_rd_idx   = idx;
  assign wr_from_prog = (state == spike_gen_pkg::prog_write);
  assign mem_wr_idx   = wr_from_prog ? prog_gen_idx : idx;

  // write-back and spike load happen in the same cycle
  always_comb begin
    mem_we   = 1'b0;
    out_load = 1'b0;
    case (state)
      spike_gen_pkg::prog_write: begin
        mem_we = 1'b1;
      end
      spike_gen_pkg::update: begin
        // hold the entry untouched while a spike waits for room
        if (!(emit && out_busy)) begin
          mem_we   = 1'b1;
          out_load = emit;
        end
      end
      spike_gen_pkg::emit_wait: begin
        if (!out_busy) begin
          mem_we   = 1'b1;
          out_load = 1'b1;
        end
      end
      default: begin
        mem_we = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= spike_gen_pkg::idle;
      idx        <= '0;
      used_q     <= '0;
      en_q       <= '0;
      pending    <= 1'b0;
      prog_armed <= 1'b1;
      prog_a     <= 1'b0;
    end else begin
      // prog_a lands one cycle after the write
      prog_a <= wr_from_prog;
      if (!prog_v) begin
        prog_armed <= 1'b1;
      end
      // one-deep memory for a pulse that lands mid-sweep
      if (unit_pulse && state != spike_gen_pkg::idle) begin
        pending <= 1'b1;
      end
      case (state)
        spike_gen_pkg::idle: begin
          if (start) begin
            pending <= 1'b0;
            used_q  <= used_clamped;
            en_q    <= gens_en;
            idx     <= '0;
            if (used_clamped != '0) begin
              state <= spike_gen_pkg::read;
            end
          end else if (prog_v && prog_armed) begin
            prog_armed <= 1'b0;
            state      <= spike_gen_pkg::prog_write;
          end
        end
        spike_gen_pkg::prog_write: begin
          state <= spike_gen_pkg::idle;
        end
        spike_gen_pkg::read: begin
          // unprogrammed entries are skipped
          state <= entry_valid ? spike_gen_pkg::update : spike_gen_pkg::next;
        end
        spike_gen_pkg::update: begin
          state <= (emit && out_busy) ? spike_gen_pkg::emit_wait : spike_gen_pkg::next;
        end
        spike_gen_pkg::emit_wait: begin
          if (!out_busy) begin
            state <= spike_gen_pkg::next;
          end
        end
        spike_gen_pkg::next: begin
          if (last_gen) begin
            state <= spike_gen_pkg::idle;
          end else begin
            idx   <= idx + 1'b1;
            state <= spike_gen_pkg::read;
          end
        end
        default: begin
          state <= spike_gen_pkg::idle;
        end
      endcase
    end
  end

endmodule

// ==== rtl/spike_gen_array.sv ====
`timescale 1ns/1ns

module spike_gen_array (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                unit_pulse,
  input  logic [spike_gen_pkg::n_gen_idx:0]   gens_used,
  input  logic [spike_gen_pkg::n_gens-1:0]    gens_en,
  input  logic                                prog_v,
  input  logic [spike_gen_pkg::n_gen_idx-1:0] prog_gen_idx,
  input  logic [spike_gen_pkg::n_period-1:0]  prog_period,
  input  logic [spike_gen_pkg::n_period-1:0]  prog_ticks,
  input  logic [spike_gen_pkg::n_tag-1:0]     prog_tag,
  output logic                                prog_a,
  output logic                                out_v,
  output logic [spike_gen_pkg::n_tag-1:0]     out_tag,
  output logic [spike_gen_pkg::n_ct-1:0]      out_ct,
  input  logic                                out_a
);

  logic [spike_gen_pkg::n_gen_idx-1:0] mem_rd_idx;
  logic [spike_gen_pkg::n_gen_idx-1:0] mem_wr_idx;
  logic                                mem_we;
  logic                                wr_from_prog;
  logic                                out_load;
  logic                                out_busy;
  logic                                fire;
  logic                                rd_valid;
  logic [spike_gen_pkg::n_period-1:0]  rd_period;
  logic [spike_gen_pkg::n_period-1:0]  rd_ticks;
  logic [spike_gen_pkg::n_tag-1:0]     rd_tag;
  logic [spike_gen_pkg::n_ct-1:0]      rd_ct;
  logic [spike_gen_pkg::n_period-1:0]  next_ticks;
  logic [spike_gen_pkg::n_ct-1:0]      next_ct;

  spike_sweep_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .unit_pulse   (unit_pulse),
    .gens_used    (gens_used),
    .gens_en      (gens_en),
    .prog_v       (prog_v),
    .prog_gen_idx (prog_gen_idx),
    .fire         (fire),
    .out_busy     (out_busy),
    .entry_valid  (rd_valid),
    .prog_a       (prog_a),
    .mem_rd_idx   (mem_rd_idx),
    .mem_we       (mem_we),
    .mem_wr_idx   (mem_wr_idx),
    .wr_from_prog (wr_from_prog),
    .out_load     (out_load)
  );

  gen_state_mem u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_idx       (mem_rd_idx),
    .we           (mem_we),
    .wr_idx       (mem_wr_idx),
    .wr_from_prog (wr_from_prog),
    .prog_period  (prog_period),
    .prog_ticks   (prog_ticks),
    .prog_tag     (prog_tag),
    .next_ticks   (next_ticks),
    .next_ct      (next_ct),
    .rd_period    (rd_period),
    .rd_ticks     (rd_ticks),
    .rd_tag       (rd_tag),
    .rd_ct        (rd_ct),
    .rd_valid     (rd_valid)
  );

  // count only moves together with an emitted spike, so the load strobe
  // doubles as the enable of the increment
  gen_tick_update u_tick (
    .clk        (clk),
    .rst_n      (rst_n),
    .period     (rd_period),
    .ticks      (rd_ticks),
    .ct         (rd_ct),
    .en         (out_load),
    .fire       (fire),
    .next_ticks (next_ticks),
    .next_ct    (next_ct)
  );

  // spike word is taken before the write-back, so it carries the old count
  spike_out_reg u_out (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (out_load),
    .tag     (rd_tag),
    .ct      (rd_ct),
    .out_a   (out_a),
    .out_v   (out_v),
    .out_tag (out_tag),
    .out_ct  (out_ct),
    .busy    (out_busy)
  );

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int half_period  = 2;
  localparam int reset_cycles = 8;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release just after an edge, like every other input
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== testbench/spike_gen_checker.sv ====
`timescale 1ns/1ns

module spike_gen_checker (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                unit_pulse,
  input  logic [spike_gen_pkg::n_gen_idx:0]   gens_used,
  input  logic [spike_gen_pkg::n_gens-1:0]    gens_en,
  input  logic                                prog_v,
  input  logic                                prog_a,
  input  logic [spike_gen_pkg::n_gen_idx-1:0] prog_gen_idx,
  input  logic [spike_gen_pkg::n_period-1:0]  prog_period,
  input  logic [spike_gen_pkg::n_period-1:0]  prog_ticks,
  input  logic [spike_gen_pkg::n_tag-1:0]     prog_tag,
  input  logic                                out_v,
  input  logic                                out_a,
  input  logic [spike_gen_pkg::n_tag-1:0]     out_tag,
  input  logic [spike_gen_pkg::n_ct-1:0]      out_ct,
  input  logic                                new_test,
  input  logic                                check_total,
  input  int                                  exp_total,
  output int                                  err_count,
  output int                                  test_spikes,
  output int                                  spikes_owed
);

  logic [spike_gen_pkg::n_period-1:0] period_m [spike_gen_pkg::n_gens];
  logic [spike_gen_pkg::n_period-1:0] ticks_m  [spike_gen_pkg::n_gens];
  logic [spike_gen_pkg::n_tag-1:0]    tag_m    [spike_gen_pkg::n_gens];
  logic [spike_gen_pkg::n_ct-1:0]     ct_m     [spike_gen_pkg::n_gens];
  logic [spike_gen_pkg::n_gens-1:0]   prog_m;

  // expected spike words with the oldest first
  logic [spike_gen_pkg::n_tag-1:0] tag_q [$];
  logic [spike_gen_pkg::n_ct-1:0]  ct_q  [$];

  // one time unit over generators 0 .. gens_used-1
  task automatic model_sweep();
    int used;
    used = (gens_used > spike_gen_pkg::n_gens) ? spike_gen_pkg::n_gens : int'(gens_used);
    for (int i = 0; i < used; i++) begin
      if (prog_m[i] && ticks_m[i] == '0) begin
        // period 0 reloads like period 1
        ticks_m[i] = (period_m[i] == '0) ? '0 : period_m[i] - 1'b1;
        if (gens_en[i]) begin
          tag_q.push_back(tag_m[i]);
          ct_q.push_back(ct_m[i]);
          ct_m[i] = ct_m[i] + 1'b1;
        end
      end else if (prog_m[i]) begin
        ticks_m[i] = ticks_m[i] - 1'b1;
      end
    end
  endtask

  task automatic check_spike();
    test_spikes++;
    if (tag_q.size() == 0) begin
      $display("spike with tag %h was sent while no spike was expected", out_tag);
      err_count++;
    end else begin
      if (out_tag !== tag_q[0]) begin
        $display("mismatch out_tag: got %h, expected %h", out_tag, tag_q[0]);
        err_count++;
      end
      if (out_ct !== ct_q[0]) begin
        $display("mismatch out_ct: got %h, expected %h", out_ct, ct_q[0]);
        err_count++;
      end
      tag_q.delete(0);
      ct_q.delete(0);
    end
  endtask

  // sampled mid-cycle between the drive and the next edge
  always @(negedge clk) begin
    if (!rst_n) begin
      prog_m = '0;
      tag_q.delete();
      ct_q.delete();
      err_count   = 0;
      test_spikes = 0;
    end else begin
      if (prog_v && prog_a) begin
        period_m[prog_gen_idx] = prog_period;
        ticks_m[prog_gen_idx]  = prog_ticks;
        tag_m[prog_gen_idx]    = prog_tag;
        ct_m[prog_gen_idx]     = '0;
        prog_m[prog_gen_idx]   = 1'b1;
      end
      if (out_v && out_a) check_spike();
      if (unit_pulse) model_sweep();
      if (new_test) test_spikes = 0;
      if (check_total) begin
        if (test_spikes != exp_total) begin
          $display("mismatch test_spikes: got %h, expected %h", test_spikes, exp_total);
          err_count++;
        end
        if (tag_q.size() != 0) begin
          $display("%0d expected spikes were never sent", tag_q.size());
          err_count++;
        end
      end
    end
    spikes_owed = tag_q.size();
  end

endmodule

// ==== testbench/spike_gen_array_properties.sv ====
`timescale 1ns/1ns

module spike_gen_array_properties (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            out_v,
  input logic                            out_a,
  input logic [spike_gen_pkg::n_tag-1:0] out_tag,
  input logic [spike_gen_pkg::n_ct-1:0]  out_ct,
  input logic                            prog_v,
  input logic                            prog_a,
  input logic                            mem_we,
  input logic                            wr_from_prog
);

  int fail_count = 0;

  // a held spike keeps its word until the transfer
  spike_held: assert property (@(posedge clk) disable iff (!rst_n)
    out_v && !out_a |=> out_v && $stable(out_tag) && $stable(out_ct))
    else begin
      $error("spike word dropped or changed before out_a");
      fail_count++;
    end

  prog_a_single: assert property (@(posedge clk) disable iff (!rst_n)
    prog_a |=> !prog_a)
    else begin
      $error("prog_a held longer than one cycle");
      fail_count++;
    end

  // prog_a answers a held request right after its entry was written
  prog_a_after_write: assert property (@(posedge clk) disable iff (!rst_n)
    prog_a |-> prog_v && $past(mem_we && wr_from_prog))
    else begin
      $error("prog_a without a programming write");
      fail_count++;
    end

endmodule

bind spike_gen_array spike_gen_array_properties u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .out_v        (out_v),
  .out_a        (out_a),
  .out_tag      (out_tag),
  .out_ct       (out_ct),
  .prog_v       (prog_v),
  .prog_a       (prog_a),
  .mem_we       (mem_we),
  .wr_from_prog (wr_from_prog)
);

// ==== testbench/spike_gen_array_tb.sv ====
`timescale 1ns/1ns

module spike_gen_array_tb;

  localparam int pulse_gap     = 32;
  localparam int settle_cycles = 64;
  localparam int drain_cycles  = 256;

  logic                                clk;
  logic                                rst_n;
  logic                                unit_pulse;
  logic [spike_gen_pkg::n_gen_idx:0]   gens_used;
  logic [spike_gen_pkg::n_gens-1:0]    gens_en;
  logic                                prog_v;
  logic [spike_gen_pkg::n_gen_idx-1:0] prog_gen_idx;
  logic [spike_gen_pkg::n_period-1:0]  prog_period;
  logic [spike_gen_pkg::n_period-1:0]  prog_ticks;
  logic [spike_gen_pkg::n_tag-1:0]     prog_tag;
  logic                                prog_a;
  logic                                out_v;
  logic [spike_gen_pkg::n_tag-1:0]     out_tag;
  logic [spike_gen_pkg::n_ct-1:0]      out_ct;
  logic                                out_a;
  logic                                new_test;
  logic                                check_total;
  int                                  exp_total;
  int                                  err_count;
  int                                  test_spikes;
  int                                  spikes_owed;
  int                                  cycles = 0;
  int                                  cycle_limit = 0;
  int                                  ack_delay;
  int                                  test_num;
  int                                  tests_run;
  int                                  tests_failed;
  int                                  errs_before;
  string                               lines [$];

  tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

  spike_gen_array dut (.*);

  spike_gen_checker u_chk (.*);

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic program_gen(input int g, input int period, input int ticks, input int tag);
    prog_gen_idx = spike_gen_pkg::n_gen_idx'(g);
    prog_period  = spike_gen_pkg::n_period'(period);
    prog_ticks   = spike_gen_pkg::n_period'(ticks);
    prog_tag     = spike_gen_pkg::n_tag'(tag);
    prog_v       = 1'b1;
    do begin
      next_cycle();
    end while (!prog_a);
    // keep the request up through the edge that ends the prog_a cycle
    next_cycle();
    prog_v = 1'b0;
    next_cycle();
  endtask

  task automatic set_conf(input int used, input int en);
    gens_used = (spike_gen_pkg::n_gen_idx + 1)'(used);
    gens_en   = spike_gen_pkg::n_gens'(en);
    next_cycle();
  endtask

  task automatic send_units(input int count);
    repeat (count) begin
      unit_pulse = 1'b1;
      next_cycle();
      unit_pulse = 1'b0;
      repeat (pulse_gap - 1) next_cycle();
    end
  endtask

  task automatic start_test(input int num);
    test_num    = num;
    errs_before = err_count;
    new_test    = 1'b1;
    next_cycle();
    new_test = 1'b0;
  endtask

  task automatic finish_test(input int total);
    int waited;
    waited = 0;
    // wait for the owed spikes to drain, up to drain_cycles
    while ((spikes_owed != 0 || out_v) && waited < drain_cycles) begin
      next_cycle();
      waited++;
    end
    // time for trailing sweeps to close
    repeat (settle_cycles) next_cycle();
    exp_total   = total;
    check_total = 1'b1;
    next_cycle();
    check_total = 1'b0;
    tests_run++;
    if (err_count != errs_before) tests_failed++;
    $display("test %0d: %0d spikes, expected %0d, %s", test_num, test_spikes, total,
             (err_count == errs_before) ? "ok" : "failed");
  endtask

  // acknowledge each spike after 0 to 5 cycles
  initial begin
    void'($urandom(32'h245616d0));
    out_a     = 1'b0;
    ack_delay = $urandom % 6;
    forever begin
      next_cycle();
      if (out_a) begin
        out_a     = 1'b0;
        ack_delay = $urandom % 6;
      end else if (out_v) begin
        if (ack_delay == 0) out_a = 1'b1;
        else ack_delay--;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int    fd;
    int    code;
    int    a;
    int    b;
    int    c;
    int    d;
    int    units_total;
    string line;
    string cmd;
    unit_pulse   = 1'b0;
    gens_used    = '0;
    gens_en      = '0;
    prog_v       = 1'b0;
    prog_gen_idx = '0;
    prog_period  = '0;
    prog_ticks   = '0;
    prog_tag     = '0;
    new_test     = 1'b0;
    check_total  = 1'b0;
    exp_total    = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_num     = 0;
    errs_before  = 0;
    fd = $fopen("testbench/spike_gen_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      $display("Simulation failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0) lines.push_back(line);
      end
      $fclose(fd);
      units_total = 0;
      foreach (lines[k]) begin
        cmd  = "";
        code = $sscanf(lines[k], "%s %d", cmd, a);
        if (cmd == "units") units_total += a;
      end
      cycle_limit = units_total * pulse_gap * 2 + 2000;
      wait (rst_n == 1'b1);
      next_cycle();
      foreach (lines[k]) begin
        cmd  = "";
        code = $sscanf(lines[k], "%s %d %d %d %d", cmd, a, b, c, d);
        if (cmd == "test") start_test(a);
        else if (cmd == "prog") program_gen(a, b, c, d);
        else if (cmd == "conf") set_conf(a, b);
        else if (cmd == "units") send_units(a);
        else if (cmd == "expect") finish_test(a);
      end
      $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
               tests_run, tests_failed, err_count, dut.u_props.fail_count);
      if (tests_run > 0 && tests_failed == 0 && err_count == 0 &&
          dut.u_props.fail_count == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// ==== testbench/spike_gen_stim.txt ====
# test <n> | prog <gen> <period> <ticks> <tag> | conf <gens_used> <gens_en>
# units <count> | expect <spike total of the test>, all numbers decimal
test 1
prog 0 2 0 512
prog 1 4 2 513
conf 2 3
units 8
expect 6
test 2
conf 2 2
units 6
expect 1
test 3
conf 2 3
units 4
expect 3
test 4
prog 2 0 0 2047
prog 3 1 0 291
conf 3 255
units 5
expect 10
test 5
prog 4 3 1 68
conf 5 31
units 6
expect 18
test 6
prog 0 5 0 768
units 3
expect 9
test 7
prog 3 1 0 1023
conf 4 8
units 1030
expect 1030

// ==== spike_gen_array.f ====
rtl/spike_gen_pkg.sv
rtl/gen_state_mem.sv
rtl/gen_tick_update.sv
rtl/spike_out_reg.sv
rtl/spike_sweep_ctrl.sv
rtl/spike_gen_array.sv
testbench/tb_clk_gen.sv
testbench/spike_gen_checker.sv
testbench/spike_gen_array_properties.sv
testbench/spike_gen_array_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module spike_gen_array_tb -f spike_gen_array.f -o sim_tb

sim_out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Simulation passed"; then
  exit 0
else
  exit 1
fi
